// File: hdl/vp8_enc_pkg.sv
// VP8 transform engine shared definitions

package vp8_enc_pkg;

    // --------------------------------------------------
    // Block geometry and widths
    // --------------------------------------------------
    localparam int BLK_DIM = 4;                  // Block edge
    localparam int BLK_PIX = BLK_DIM * BLK_DIM;  // Pixels per block
    localparam int PIX_W   = 8;
    localparam int COEF_W  = 12;
    localparam int WORD_W  = 32;

    // Word offsets from the block base
    localparam int SRC_OFS  = 0;  // Source rows
    localparam int REF_OFS  = 4;  // Prediction rows
    localparam int COEF_OFS = 8;  // Coefficient pairs

    // --------------------------------------------------
    // Memory word, read as pixels or as coefficients
    // --------------------------------------------------
    // pix[0] is the low byte and coef[0] holds the even index
    typedef union packed {
        logic        [BLK_DIM-1:0][PIX_W-1:0]    pix;
        logic signed [1:0][WORD_W/2-1:0]         coef;
    } mem_word_t;

endpackage

// File: hdl/fdct4x4.sv
// Pipelined 4x4 forward DCT
`timescale 1ns/10ps

module fdct4x4 (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                start_i,
    input  logic [vp8_enc_pkg::BLK_PIX*vp8_enc_pkg::PIX_W-1:0]  src_i,
    input  logic [vp8_enc_pkg::BLK_PIX*vp8_enc_pkg::PIX_W-1:0]  ref_i,
    output logic [vp8_enc_pkg::BLK_PIX*vp8_enc_pkg::COEF_W-1:0] coef_o,
    output logic                                                done_o
);
    import vp8_enc_pkg::*;

    localparam int TMP_W = 14;  // Row pass precision

    logic signed [TMP_W-1:0]  tmp_d [BLK_PIX];
    logic signed [TMP_W-1:0]  tmp_q [BLK_PIX];
    logic signed [COEF_W-1:0] out_d [BLK_PIX];
    logic signed [COEF_W-1:0] out_q [BLK_PIX];
    logic                     start_q;

    // Two-flop strobe follows the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            start_q <= start_i;
            done_o  <= start_q;
        end
    end

    // --------------------------------------------------
    // Stage 1: residual and row butterflies
    // --------------------------------------------------
    always_comb begin : row_pass
        int d [BLK_DIM];
        int a0, a1, a2, a3;
        int base;
        for (int r = 0; r < BLK_DIM; r++) begin
            base = r * BLK_DIM;
            for (int c = 0; c < BLK_DIM; c++) begin
                d[c] = int'(src_i[PIX_W*(base+c) +: PIX_W])
                     - int'(ref_i[PIX_W*(base+c) +: PIX_W]);
            end
            a0 = d[0] + d[3];
            a1 = d[1] + d[2];
            a2 = d[1] - d[2];
            a3 = d[0] - d[3];
            tmp_d[base+0] = TMP_W'((a0 + a1) * 8);
            tmp_d[base+1] = TMP_W'((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
            tmp_d[base+2] = TMP_W'((a0 - a1) * 8);
            tmp_d[base+3] = TMP_W'((a3 * 2217 - a2 * 5352 + 937) >>> 9);
        end
    end

    // --------------------------------------------------
    // Stage 2: column butterflies and final rounding
    // --------------------------------------------------
    always_comb begin : col_pass
        int b0, b1, b2, b3;
        for (int c = 0; c < BLK_DIM; c++) begin
            b0 = int'(tmp_q[c]) + int'(tmp_q[c+3*BLK_DIM]);
            b1 = int'(tmp_q[c+BLK_DIM]) + int'(tmp_q[c+2*BLK_DIM]);
            b2 = int'(tmp_q[c+BLK_DIM]) - int'(tmp_q[c+2*BLK_DIM]);
            b3 = int'(tmp_q[c]) - int'(tmp_q[c+3*BLK_DIM]);
            out_d[c]           = COEF_W'((b0 + b1 + 7) >>> 4);
            out_d[c+BLK_DIM]   = COEF_W'(((b2 * 2217 + b3 * 5352 + 12000) >>> 16)
                                         + int'(b3 != 0));  // Bias for nonzero b3
            out_d[c+2*BLK_DIM] = COEF_W'((b0 - b1 + 7) >>> 4);
            out_d[c+3*BLK_DIM] = COEF_W'((b3 * 2217 - b2 * 5352 + 51000) >>> 16);
        end
    end

    // Both stages load every cycle
    always_ff @(posedge clk) begin
        tmp_q <= tmp_d;
        out_q <= out_d;
    end

    always_comb begin
        for (int k = 0; k < BLK_PIX; k++) begin
            coef_o[COEF_W*k +: COEF_W] = out_q[k];
        end
    end

endmodule

// File: hdl/block_fetch.sv
// Job control and block fetcher
`timescale 1ns/10ps

module block_fetch #(
    parameter int ADDR_W = 8
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               start_i,
    input  logic [ADDR_W-1:0]                                  base_i,
    input  logic                                               store_done_i,
    output logic                                               mem_req_o,
    output logic [ADDR_W-1:0]                                  mem_addr_o,
    input  logic                                               mem_gnt_i,
    input  vp8_enc_pkg::mem_word_t                             mem_rdata_i,
    input  logic                                               mem_rvalid_i,
    output logic                                               busy_o,
    output logic [ADDR_W-1:0]                                  job_base_o,
    output logic [vp8_enc_pkg::BLK_PIX*vp8_enc_pkg::PIX_W-1:0] src_o,
    output logic [vp8_enc_pkg::BLK_PIX*vp8_enc_pkg::PIX_W-1:0] ref_o,
    output logic                                               dct_start_o
);
    import vp8_enc_pkg::*;

    localparam int ROW_W  = BLK_DIM * PIX_W;
    localparam int ROW_AW = $clog2(BLK_DIM);

    logic                          busy_q;
    logic [ADDR_W-1:0]             base_q;
    logic [ROW_AW+1:0]             issue_q;  // Reads issued, 0..8
    logic [ROW_AW:0]               ret_q;    // Rows returned
    logic [BLK_DIM-1:0][ROW_W-1:0] src_q;
    logic [BLK_DIM-1:0][ROW_W-1:0] ref_q;
    logic [ADDR_W-1:0]             row_ofs;
    logic                          start_ok;

    // Store done frees the engine in the same cycle
    assign busy_o     = busy_q & ~store_done_i;
    assign start_ok   = start_i & ~busy_o;
    assign job_base_o = base_q;
    assign src_o      = src_q;
    assign ref_o      = ref_q;

    // Source rows first, then reference rows
    assign row_ofs = issue_q[ROW_AW] ? ADDR_W'(REF_OFS) + ADDR_W'(issue_q[ROW_AW-1:0])
                                     : ADDR_W'(SRC_OFS) + ADDR_W'(issue_q[ROW_AW-1:0]);
    assign mem_addr_o = base_q + row_ofs;
    assign mem_req_o  = busy_q & ~issue_q[ROW_AW+1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            base_q      <= '0;
            issue_q     <= '0;
            ret_q       <= '0;
            dct_start_o <= 1'b0;
        end else begin
            dct_start_o <= mem_rvalid_i & (&ret_q);  // Last row back
            if (start_ok) begin
                busy_q  <= 1'b1;
                base_q  <= base_i;
                issue_q <= '0;
                ret_q   <= '0;
            end else begin
                if (store_done_i) busy_q <= 1'b0;
                if (mem_gnt_i) issue_q <= issue_q + 1'b1;
                if (mem_rvalid_i) ret_q <= ret_q + 1'b1;
            end
        end
    end

    // Row capture
    always_ff @(posedge clk) begin
        if (mem_rvalid_i) begin
            if (ret_q[ROW_AW]) ref_q[ret_q[ROW_AW-1:0]] <= mem_rdata_i.pix;
            else               src_q[ret_q[ROW_AW-1:0]] <= mem_rdata_i.pix;
        end
    end

endmodule

// File: hdl/coef_store.sv
// Coefficient block writer
`timescale 1ns/10ps

module coef_store #(
    parameter int ADDR_W = 8
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [ADDR_W-1:0]                                   job_base_i,
    input  logic [vp8_enc_pkg::BLK_PIX*vp8_enc_pkg::COEF_W-1:0] coef_i,
    input  logic                                                coef_valid_i,
    output logic                                                mem_req_o,
    output logic [ADDR_W-1:0]                                   mem_addr_o,
    output vp8_enc_pkg::mem_word_t                              mem_wdata_o,
    input  logic                                                mem_gnt_i,
    output logic                                                store_done_o
);
    import vp8_enc_pkg::*;

    localparam int N_WR   = BLK_PIX / 2;  // Two coefficients per word
    localparam int HALF_W = WORD_W / 2;

    logic [BLK_PIX-1:0][COEF_W-1:0] coef_q;
    logic                           active_q;
    logic [$clog2(N_WR)-1:0]        cnt_q;
    logic [COEF_W-1:0]              c_even;
    logic [COEF_W-1:0]              c_odd;

    assign mem_req_o  = active_q;
    assign mem_addr_o = job_base_i + ADDR_W'(COEF_OFS) + ADDR_W'(cnt_q);
    assign c_even     = coef_q[{cnt_q, 1'b0}];
    assign c_odd      = coef_q[{cnt_q, 1'b1}];

    // Sign extend each coefficient into its half
    always_comb begin
        mem_wdata_o.coef[0] = {{(HALF_W-COEF_W){c_even[COEF_W-1]}}, c_even};
        mem_wdata_o.coef[1] = {{(HALF_W-COEF_W){c_odd[COEF_W-1]}}, c_odd};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q     <= 1'b0;
            cnt_q        <= '0;
            store_done_o <= 1'b0;
        end else begin
            store_done_o <= mem_gnt_i & (&cnt_q);
            if (coef_valid_i) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (mem_gnt_i) begin
                cnt_q <= cnt_q + 1'b1;
                if (&cnt_q) active_q <= 1'b0;  // Last pair written
            end
        end
    end

    always_ff @(posedge clk) begin
        if (coef_valid_i) coef_q <= coef_i;
    end

endmodule

// File: hdl/mem_arbiter.sv
// Round-robin memory arbiter
`timescale 1ns/10ps

module mem_arbiter #(
    parameter int ADDR_W = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // Host
    input  logic                           host_req_i,
    input  logic                           host_we_i,
    input  logic [ADDR_W-1:0]              host_addr_i,
    input  logic [vp8_enc_pkg::WORD_W-1:0] host_wdata_i,
    output logic                           host_gnt_o,
    output logic [vp8_enc_pkg::WORD_W-1:0] host_rdata_o,
    output logic                           host_rvalid_o,
    // Block fetcher
    input  logic                           fetch_req_i,
    input  logic                           fetch_we_i,
    input  logic [ADDR_W-1:0]              fetch_addr_i,
    input  logic [vp8_enc_pkg::WORD_W-1:0] fetch_wdata_i,
    output logic                           fetch_gnt_o,
    output logic [vp8_enc_pkg::WORD_W-1:0] fetch_rdata_o,
    output logic                           fetch_rvalid_o,
    // Coefficient store
    input  logic                           store_req_i,
    input  logic                           store_we_i,
    input  logic [ADDR_W-1:0]              store_addr_i,
    input  logic [vp8_enc_pkg::WORD_W-1:0] store_wdata_i,
    output logic                           store_gnt_o,
    output logic [vp8_enc_pkg::WORD_W-1:0] store_rdata_o,
    output logic                           store_rvalid_o,
    // Memory
    output logic                           ram_we_o,
    output logic [ADDR_W-1:0]              ram_addr_o,
    output logic [vp8_enc_pkg::WORD_W-1:0] ram_wdata_o,
    input  logic [vp8_enc_pkg::WORD_W-1:0] ram_rdata_i
);
    import vp8_enc_pkg::*;

    localparam int N_PEER = 3;

    logic [N_PEER-1:0] req;
    logic [N_PEER-1:0] we;
    logic [N_PEER-1:0] gnt;
    logic [N_PEER-1:0] rd_q;    // Peer whose read is in flight
    logic [ADDR_W-1:0] addr [N_PEER];
    logic [WORD_W-1:0] wdata [N_PEER];
    logic [1:0]        last_q;  // Last granted peer
    logic [1:0]        sel;

    assign req   = {store_req_i, fetch_req_i, host_req_i};
    assign we    = {store_we_i, fetch_we_i, host_we_i};
    assign addr  = '{host_addr_i, fetch_addr_i, store_addr_i};
    assign wdata = '{host_wdata_i, fetch_wdata_i, store_wdata_i};

    // Search starts just after the last winner
    always_comb begin : pick
        int idx;
        gnt = '0;
        sel = last_q;
        for (int k = 1; k <= N_PEER; k++) begin
            idx = (int'(last_q) + k) % N_PEER;
            if (req[idx] && gnt == '0) begin
                gnt[idx] = 1'b1;
                sel      = 2'(idx);
            end
        end
    end

    assign ram_we_o    = (|gnt) & we[sel];
    assign ram_addr_o  = addr[sel];
    assign ram_wdata_o = wdata[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= 2'(N_PEER - 1);  // Host wins first
            rd_q   <= '0;
        end else begin
            if (|gnt) last_q <= sel;
            rd_q <= gnt & ~we;
        end
    end

    // --------------------------------------------------
    // Read return, to the requesting peer only
    // --------------------------------------------------
    assign host_gnt_o     = gnt[0];
    assign fetch_gnt_o    = gnt[1];
    assign store_gnt_o    = gnt[2];
    assign host_rvalid_o  = rd_q[0];
    assign fetch_rvalid_o = rd_q[1];
    assign store_rvalid_o = rd_q[2];
    assign host_rdata_o   = rd_q[0] ? ram_rdata_i : '0;
    assign fetch_rdata_o  = rd_q[1] ? ram_rdata_i : '0;
    assign store_rdata_o  = rd_q[2] ? ram_rdata_i : '0;

endmodule

// File: hdl/block_ram.sv
// Single-port block memory
`timescale 1ns/10ps

module block_ram #(
    parameter int ADDR_W = 8
) (
    input  logic                           clk,
    input  logic                           we_i,
    input  logic [ADDR_W-1:0]              addr_i,
    input  logic [vp8_enc_pkg::WORD_W-1:0] wdata_i,
    output logic [vp8_enc_pkg::WORD_W-1:0] rdata_o
);

    logic [vp8_enc_pkg::WORD_W-1:0] mem [2**ADDR_W];

    // Read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we_i) mem[addr_i] <= wdata_i;
        rdata_o <= mem[addr_i];
    end

endmodule

// File: hdl/dct_engine_top.sv
// Forward transform engine top level
`timescale 1ns/10ps

module dct_engine_top #(
    parameter int ADDR_W = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [ADDR_W-1:0]              base_i,
    output logic                           busy_o,
    output logic                           done_o,
    input  logic                           host_req_i,
    input  logic                           host_we_i,
    input  logic [ADDR_W-1:0]              host_addr_i,
    input  logic [vp8_enc_pkg::WORD_W-1:0] host_wdata_i,
    output logic                           host_gnt_o,
    output logic [vp8_enc_pkg::WORD_W-1:0] host_rdata_o,
    output logic                           host_rvalid_o
);
    import vp8_enc_pkg::*;

    // Fetch peer
    logic                        fetch_req;
    logic                        fetch_gnt;
    logic                        fetch_rvalid;
    logic [ADDR_W-1:0]           fetch_addr;
    mem_word_t                   fetch_rdata;
    logic [ADDR_W-1:0]           job_base;
    // Transform path
    logic [BLK_PIX*PIX_W-1:0]    src_blk;
    logic [BLK_PIX*PIX_W-1:0]    ref_blk;
    logic                        dct_start;
    logic [BLK_PIX*COEF_W-1:0]   coef;
    logic                        coef_done;
    // Store peer
    logic                        store_req;
    logic                        store_gnt;
    logic [ADDR_W-1:0]           store_addr;
    mem_word_t                   store_wdata;
    logic                        store_done;
    // Memory
    logic                        ram_we;
    logic [ADDR_W-1:0]           ram_addr;
    logic [WORD_W-1:0]           ram_wdata;
    logic [WORD_W-1:0]           ram_rdata;

    assign done_o = store_done;

    block_fetch #(.ADDR_W(ADDR_W)) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .base_i       (base_i),
        .store_done_i (store_done),
        .mem_req_o    (fetch_req),
        .mem_addr_o   (fetch_addr),
        .mem_gnt_i    (fetch_gnt),
        .mem_rdata_i  (fetch_rdata),
        .mem_rvalid_i (fetch_rvalid),
        .busy_o       (busy_o),
        .job_base_o   (job_base),
        .src_o        (src_blk),
        .ref_o        (ref_blk),
        .dct_start_o  (dct_start)
    );

    fdct4x4 u_fdct (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (dct_start),
        .src_i   (src_blk),
        .ref_i   (ref_blk),
        .coef_o  (coef),
        .done_o  (coef_done)
    );

    coef_store #(.ADDR_W(ADDR_W)) u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_base_i   (job_base),
        .coef_i       (coef),
        .coef_valid_i (coef_done),
        .mem_req_o    (store_req),
        .mem_addr_o   (store_addr),
        .mem_wdata_o  (store_wdata),
        .mem_gnt_i    (store_gnt),
        .store_done_o (store_done)
    );

    // Fetcher only reads and the store only writes
    mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_req_i     (host_req_i),
        .host_we_i      (host_we_i),
        .host_addr_i    (host_addr_i),
        .host_wdata_i   (host_wdata_i),
        .host_gnt_o     (host_gnt_o),
        .host_rdata_o   (host_rdata_o),
        .host_rvalid_o  (host_rvalid_o),
        .fetch_req_i    (fetch_req),
        .fetch_we_i     (1'b0),
        .fetch_addr_i   (fetch_addr),
        .fetch_wdata_i  ('0),
        .fetch_gnt_o    (fetch_gnt),
        .fetch_rdata_o  (fetch_rdata),
        .fetch_rvalid_o (fetch_rvalid),
        .store_req_i    (store_req),
        .store_we_i     (1'b1),
        .store_addr_i   (store_addr),
        .store_wdata_i  (store_wdata),
        .store_gnt_o    (store_gnt),
        .store_rdata_o  (),
        .store_rvalid_o (),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata)
    );

    block_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: sim/fdct_ref.svh
// Reference forward DCT model
`ifndef FDCT_REF_SVH
`define FDCT_REF_SVH

// Keep the low bits and sign extend them again
function automatic int wrap_to(input int val, input int bits);
    int sh;
    sh = 32 - bits;
    return (val <<< sh) >>> sh;
endfunction

// Expected coefficients, index 4*row + column
function automatic logic [15:0][11:0] fdct_ref(input logic [15:0][7:0] src,
                                               input logic [15:0][7:0] prd);
    int                t [16];  // Row pass results, 14-bit
    int                d [4];
    int                s0, s1, s2, s3;
    logic [15:0][11:0] res;
    // Horizontal pass on the residual
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            d[c] = int'(src[4*r+c]) - int'(prd[4*r+c]);
        end
        s0 = d[0] + d[3];
        s1 = d[1] + d[2];
        s2 = d[1] - d[2];
        s3 = d[0] - d[3];
        t[4*r]   = wrap_to((s0 + s1) * 8, 14);
        t[4*r+1] = wrap_to((s2 * 2217 + s3 * 5352 + 1812) >>> 9, 14);
        t[4*r+2] = wrap_to((s0 - s1) * 8, 14);
        t[4*r+3] = wrap_to((s3 * 2217 - s2 * 5352 + 937) >>> 9, 14);
    end
    // Vertical pass
    for (int c = 0; c < 4; c++) begin
        s0 = t[c] + t[c+12];
        s1 = t[c+4] + t[c+8];
        s2 = t[c+4] - t[c+8];
        s3 = t[c] - t[c+12];
        res[c]    = 12'((s0 + s1 + 7) >>> 4);
        res[c+4]  = 12'(((s2 * 2217 + s3 * 5352 + 12000) >>> 16) + (s3 != 0 ? 1 : 0));
        res[c+8]  = 12'((s0 - s1 + 7) >>> 4);
        res[c+12] = 12'((s3 * 2217 - s2 * 5352 + 51000) >>> 16);
    end
    return res;
endfunction

`endif

// File: sim/tb_dct_engine.sv
// Transform engine testbench
`timescale 1ns/10ps

module tb_dct_engine;
    import vp8_enc_pkg::*;

    `include "fdct_ref.svh"

    localparam int TIMEOUT_CYC = 4000;  // Six tests, 600 cycles each, with margin

    logic        clk;
    logic        rst_n;
    logic        start_i;
    logic [7:0]  base_i;
    logic        busy_o;
    logic        done_o;
    logic        host_req_i;
    logic        host_we_i;
    logic [7:0]  host_addr_i;
    logic [31:0] host_wdata_i;
    logic        host_gnt_o;
    logic [31:0] host_rdata_o;
    logic        host_rvalid_o;

    integer      seed;
    int          cycle_cnt;
    int          done_cnt;
    string       cur_test;
    logic [31:0] exp_buf [256];  // Words waiting for the checker
    logic [31:0] act_buf [256];
    int          n_pushed;
    int          n_checked;
    int          cmp_errs;
    int          other_errs;
    int          n_tests;
    int          n_bad;
    int          err_snap;

    dct_engine_top #(.ADDR_W(8)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle limit and done pulse count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (done_o) done_cnt <= done_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYC) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    // Checker drains whatever the tests queued
    always @(posedge clk) begin : compare
        logic [7:0] slot;
        while (n_checked < n_pushed) begin
            slot = 8'(n_checked);
            if (act_buf[slot] !== exp_buf[slot]) begin
                $display("FAIL %s expected %h actual %h", cur_test, exp_buf[slot], act_buf[slot]);
                cmp_errs++;
            end
            n_checked++;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] fill_word(input logic [7:0] addr);
        return {addr ^ 8'h5a, 8'hc3, ~addr, addr};
    endfunction

    function automatic logic [31:0] row_word(input logic [15:0][7:0] blk, input int r);
        mem_word_t w;
        for (int c = 0; c < BLK_DIM; c++) begin
            w.pix[c] = blk[BLK_DIM*r + c];  // Pixel 0 in the low byte
        end
        return w;
    endfunction

    task automatic expect_word(input logic [31:0] exp_w, input logic [31:0] act_w);
        exp_buf[8'(n_pushed)] = exp_w;
        act_buf[8'(n_pushed)] = act_w;
        n_pushed++;
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        host_req_i   <= 1'b1;
        host_we_i    <= 1'b1;
        host_addr_i  <= addr;
        host_wdata_i <= data;
        do @(posedge clk); while (!host_gnt_o);
        host_req_i <= 1'b0;
        host_we_i  <= 1'b0;
    endtask

    task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        host_req_i  <= 1'b1;
        host_we_i   <= 1'b0;
        host_addr_i <= addr;
        do @(posedge clk); while (!host_gnt_o);
        host_req_i <= 1'b0;
        do @(posedge clk); while (!host_rvalid_o);
        data = host_rdata_o;
    endtask

    task automatic pulse_start(input logic [7:0] base);
        @(posedge clk);
        start_i <= 1'b1;
        base_i  <= base;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge clk); while (!done_o);
    endtask

    task automatic rand_block(output logic [15:0][7:0] blk);
        for (int k = 0; k < BLK_PIX; k++) begin
            blk[k] = 8'($random(seed));
        end
    endtask

    task automatic load_fill(input logic [7:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            host_write(base + 8'(i), fill_word(base + 8'(i)));
        end
    endtask

    task automatic check_fill(input logic [7:0] base, input int n);
        logic [31:0] got;
        for (int i = 0; i < n; i++) begin
            host_read(base + 8'(i), got);
            expect_word(fill_word(base + 8'(i)), got);
        end
    endtask

    // Rows and a marker in the coefficient words so a missing write shows
    task automatic load_block(input logic [7:0] base, input logic [15:0][7:0] src,
                              input logic [15:0][7:0] prd);
        for (int r = 0; r < BLK_DIM; r++) begin
            host_write(base + 8'(SRC_OFS + r), row_word(src, r));
            host_write(base + 8'(REF_OFS + r), row_word(prd, r));
        end
        load_fill(base + 8'(COEF_OFS), BLK_PIX / 2);
    endtask

    task automatic check_pixels(input logic [7:0] base, input logic [15:0][7:0] src,
                                input logic [15:0][7:0] prd);
        logic [31:0] got;
        for (int r = 0; r < BLK_DIM; r++) begin
            host_read(base + 8'(SRC_OFS + r), got);
            expect_word(row_word(src, r), got);
            host_read(base + 8'(REF_OFS + r), got);
            expect_word(row_word(prd, r), got);
        end
    endtask

    task automatic check_block(input logic [7:0] base, input logic [15:0][7:0] src,
                               input logic [15:0][7:0] prd);
        logic [15:0][11:0] exp_c;
        mem_word_t         w;
        logic [31:0]       got;
        exp_c = fdct_ref(src, prd);
        for (int k = 0; k < BLK_PIX / 2; k++) begin
            w.coef[0] = {{4{exp_c[2*k][11]}}, exp_c[2*k]};      // Even index low
            w.coef[1] = {{4{exp_c[2*k+1][11]}}, exp_c[2*k+1]};
            host_read(base + 8'(COEF_OFS + k), got);
            expect_word(w, got);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_snap = cmp_errs + other_errs;
    endtask

    task automatic end_test();
        int errs;
        while (n_checked < n_pushed) @(posedge clk);
        errs = cmp_errs + other_errs - err_snap;
        $display("%-12s finished, %0d errors", cur_test, errs);
        n_tests++;
        if (errs != 0) n_bad++;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : main
        logic [15:0][7:0] src_blk;
        logic [15:0][7:0] ref_blk;
        logic [15:0][7:0] src_set [3];
        logic [15:0][7:0] ref_set [3];
        logic [7:0]       job_base [3];
        logic [31:0]      wr_data [8];
        logic [31:0]      got;
        logic [7:0]       base;
        int               done_before;
        logic             jobs_over;

        seed         = 32'h804bc381;
        rst_n        <= 1'b0;
        start_i      <= 1'b0;
        base_i       <= '0;
        host_req_i   <= 1'b0;
        host_we_i    <= 1'b0;
        host_addr_i  <= '0;
        host_wdata_i <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        begin_test("reset_rw");
        if (busy_o || done_o || host_gnt_o) begin
            $display("After reset busy_o=%b done_o=%b host_gnt_o=%b, all should be low",
                     busy_o, done_o, host_gnt_o);
            other_errs++;
        end
        for (int i = 0; i < 8; i++) begin
            wr_data[i] = $random(seed);
            host_write(8'(240 + i), wr_data[i]);
        end
        for (int i = 0; i < 8; i++) begin
            host_read(8'(240 + i), got);
            expect_word(wr_data[i], got);
        end
        end_test();

        begin_test("single_job");
        rand_block(src_blk);
        rand_block(ref_blk);
        load_block(8'd0, src_blk, ref_blk);
        pulse_start(8'd0);
        wait_done();
        check_block(8'd0, src_blk, ref_blk);
        check_pixels(8'd0, src_blk, ref_blk);
        end_test();

        // Flat residual, then full positive and full negative swing
        begin_test("edge_blocks");
        for (int e = 0; e < 3; e++) begin
            case (e)
                0: begin
                    rand_block(src_blk);
                    ref_blk = src_blk;
                end
                1: begin
                    src_blk = {16{8'hff}};
                    ref_blk = '0;
                end
                default: begin
                    src_blk = '0;
                    ref_blk = {16{8'hff}};
                end
            endcase
            load_block(8'd32, src_blk, ref_blk);
            pulse_start(8'd32);
            wait_done();
            check_block(8'd32, src_blk, ref_blk);
        end
        end_test();

        begin_test("back_to_back");
        job_base[0] = 8'd16;
        job_base[1] = 8'd48;
        job_base[2] = 8'd200;
        load_fill(8'd128, 16);
        for (int j = 0; j < 3; j++) begin
            rand_block(src_set[j]);
            rand_block(ref_set[j]);
            load_block(job_base[j], src_set[j], ref_set[j]);
        end
        jobs_over = 1'b0;
        fork
            begin
                for (int j = 0; j < 3; j++) begin
                    pulse_start(job_base[j]);
                    wait_done();
                end
                jobs_over = 1'b1;
            end
            begin
                for (int n = 0; !jobs_over; n++) begin  // Host traffic on its own region
                    base = 8'(128 + n % 16);
                    host_read(base, got);
                    expect_word(fill_word(base), got);
                end
            end
        join
        for (int j = 0; j < 3; j++) begin
            check_block(job_base[j], src_set[j], ref_set[j]);
        end
        end_test();

        begin_test("start_busy");
        rand_block(src_blk);
        rand_block(ref_blk);
        load_block(8'd64, src_blk, ref_blk);
        load_fill(8'd96, 16);
        done_before = done_cnt;
        pulse_start(8'd64);
        do @(posedge clk); while (!busy_o);
        pulse_start(8'd96);
        wait_done();
        repeat (60) @(posedge clk);  // Room for a stray second job
        if (done_cnt - done_before != 1) begin
            $display("Start while busy gave %0d done pulses instead of 1",
                     done_cnt - done_before);
            other_errs++;
        end
        check_block(8'd64, src_blk, ref_blk);
        check_fill(8'd96, 16);
        end_test();

        begin_test("random_jobs");
        for (int n = 0; n < 20; n++) begin
            base = {4'($random(seed)), 4'h0};
            rand_block(src_blk);
            rand_block(ref_blk);
            load_block(base, src_blk, ref_blk);
            pulse_start(base);
            wait_done();
            check_block(base, src_blk, ref_blk);
        end
        end_test();

        $display("%0d tests, %0d with errors, %0d word checks, %0d errors",
                 n_tests, n_bad, n_checked, cmp_errs + other_errs);
        if (cmp_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+sim
hdl/vp8_enc_pkg.sv
hdl/fdct4x4.sv
hdl/block_fetch.sv
hdl/coef_store.sv
hdl/mem_arbiter.sv
hdl/block_ram.sv
hdl/dct_engine_top.sv
sim/tb_dct_engine.sv

// File: Makefile
TOP = tb_dct_engine

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
